// ==== xlat_unit.f ====
+incdir+verif
logic/xlat_pkg.sv
logic/tlb_lookup_if.sv
logic/csr_regs.sv
logic/tlb_array.sv
logic/flush_ctrl.sv
logic/credit_counter.sv
logic/pipe_stage.sv
logic/xlat_pipe.sv
logic/xlat_unit.sv
verif/xlat_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    -f xlat_unit.f \
    --top-module xlat_unit_tb \
    -o sim_xlat_unit

./obj_dir/sim_xlat_unit | tee sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== verif/xlat_ref.svh ====
`ifndef XLAT_REF_SVH
`define XLAT_REF_SVH

// testbench copy of the programmed state
logic                        m_da;
logic [xlat_pkg::plv_w-1:0]  m_plv;
logic [xlat_pkg::asid_w-1:0] m_asid;
xlat_pkg::dmw_t              m_dmw0;
xlat_pkg::dmw_t              m_dmw1;
xlat_pkg::tlb_entry_t        m_tlb [xlat_pkg::tlb_num];

// responses still owed by the DUT, oldest first
xlat_pkg::xlat_rsp_t exp_q [$];

function automatic logic window_hit(xlat_pkg::dmw_t w, logic [31:0] va);
    return w.plv_en[m_plv] && (va[31:29] == w.vseg);
endfunction

function automatic xlat_pkg::xlat_rsp_t ref_translate(logic [31:0] va,
                                                      xlat_pkg::acc_kind_t kind);
    xlat_pkg::xlat_rsp_t r;
    xlat_pkg::tlb_page_t pg;
    logic                found;
    r.pa    = 32'h0;
    r.ecode = xlat_pkg::ecode_none;
    pg      = '0;
    found   = 1'b0;
    for (int i = 0; i < xlat_pkg::tlb_num; i++) begin
        if (m_tlb[i].e && m_tlb[i].vppn == va[31:13]
                && (m_tlb[i].g || m_tlb[i].asid == m_asid)) begin
            found = 1'b1;
            pg    = va[12] ? m_tlb[i].page1 : m_tlb[i].page0;
        end
    end
    if (m_da) begin
        r.pa = va;
    end else if (window_hit(m_dmw0, va)) begin
        r.pa = {m_dmw0.pseg, va[28:0]};
    end else if (window_hit(m_dmw1, va)) begin
        r.pa = {m_dmw1.pseg, va[28:0]};
    end else if (!found) begin
        r.ecode = xlat_pkg::ecode_tlbr;
    end else if (!pg.v) begin
        r.ecode = (kind == xlat_pkg::acc_fetch) ? xlat_pkg::ecode_pif : xlat_pkg::ecode_pil;
    end else if (m_plv > pg.plv) begin
        r.ecode = xlat_pkg::ecode_ppi;
    end else begin
        r.pa = {pg.ppn, va[11:0]};
    end
    return r;
endfunction

`endif

// ==== verif/xlat_unit_tb.sv ====
module xlat_unit_tb;

    // generous per-request budget covers random credit return and config writes
    localparam int n_req       = 240;
    localparam int req_cycles  = 6;
    localparam int n_flush     = 1;
    localparam int flush_cycles = 24;
    localparam int max_cycles  = 2 * (n_req * req_cycles + n_flush * flush_cycles) + 200;

    logic                           clk;
    logic                           rst_n;
    logic                           req_valid;
    logic [31:0]                    req_va;
    xlat_pkg::acc_kind_t            req_kind;
    logic                           req_ready;
    logic                           rsp_valid;
    logic [31:0]                    rsp_pa;
    logic [5:0]                     rsp_ecode;
    logic                           rsp_credit = 1'b0;
    logic                           csr_we;
    logic [1:0]                     csr_sel;
    logic [31:0]                    csr_wdata;
    logic                           tlb_we;
    logic [3:0]                     tlb_index;
    xlat_pkg::tlb_entry_t           tlb_wentry;
    logic                           flush_req;
    logic                           flush_busy;

    int   val_errors   = 0;
    int   proto_errors = 0;
    int   cycles       = 0;
    int   rsp_seen     = 0;
    int   tb_credits   = xlat_pkg::xlat_credits;
    int   owed         = 0;
    logic withhold     = 1'b0;

    `include "xlat_ref.svh"

    xlat_unit dut0 (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("run stopped by timeout after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // compare responses and model the consumer's credits
    always @(negedge clk) begin
        xlat_pkg::xlat_rsp_t exp;
        logic [31:0]         r;
        r = $urandom;
        if (rst_n) begin
            if (rsp_valid) begin
                rsp_seen++;
                assert (tb_credits > 0) else begin
                    proto_errors++;
                    $display("%0t: response raised while no credit was held", $time);
                end
                tb_credits--;
                owed++;
                if (exp_q.size() == 0) begin
                    proto_errors++;
                    $display("%0t: response arrived with no request outstanding", $time);
                end else begin
                    exp = exp_q.pop_front();
                    assert (rsp_pa == exp.pa) else begin
                        val_errors++;
                        $display("ERROR %0t rsp_pa got %h expected %h", $time, rsp_pa, exp.pa);
                    end
                    assert (rsp_ecode == exp.ecode) else begin
                        val_errors++;
                        $display("ERROR %0t rsp_ecode got %h expected %h",
                                 $time, rsp_ecode, exp.ecode);
                    end
                end
            end
            assert (!(flush_busy && req_ready)) else begin
                proto_errors++;
                $display("%0t: req_ready high during a flush", $time);
            end
            rsp_credit = 1'b0;
            if (!withhold && owed > 0 && r[0]) begin
                rsp_credit = 1'b1;
                owed--;
                tb_credits++;
            end
        end
    end

    task automatic write_csr(logic [1:0] sel, logic [31:0] data);
        @(negedge clk);
        csr_we    = 1'b1;
        csr_sel   = sel;
        csr_wdata = data;
        @(negedge clk);
        csr_we    = 1'b0;
    endtask

    task automatic set_mode(logic da, logic [1:0] plv);
        write_csr(xlat_pkg::csr_sel_crmd, {28'h0, da, 1'b0, plv});
        m_da  = da;
        m_plv = plv;
    endtask

    task automatic set_asid(logic [9:0] asid);
        write_csr(xlat_pkg::csr_sel_asid, {22'h0, asid});
        m_asid = asid;
    endtask

    task automatic set_window(logic which, logic [3:0] en, logic [2:0] pseg, logic [2:0] vseg);
        xlat_pkg::dmw_t w;
        w.plv_en = en;
        w.pseg   = pseg;
        w.vseg   = vseg;
        if (which) begin
            write_csr(xlat_pkg::csr_sel_dmw1, {vseg, 1'b0, pseg, 21'h0, en});
            m_dmw1 = w;
        end else begin
            write_csr(xlat_pkg::csr_sel_dmw0, {vseg, 1'b0, pseg, 21'h0, en});
            m_dmw0 = w;
        end
    endtask

    task automatic write_entry(logic [3:0] idx, xlat_pkg::tlb_entry_t e);
        @(negedge clk);
        tlb_we     = 1'b1;
        tlb_index  = idx;
        tlb_wentry = e;
        @(negedge clk);
        tlb_we     = 1'b0;
        m_tlb[idx] = e;
    endtask

    // leaves req_valid high so requests can go back to back
    task automatic send(logic [31:0] va, xlat_pkg::acc_kind_t kind);
        @(negedge clk);
        req_valid = 1'b1;
        req_va    = va;
        req_kind  = kind;
        while (!req_ready) begin
            @(negedge clk);
        end
        exp_q.push_back(ref_translate(va, kind));
    endtask

    task automatic stop_req();
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    function automatic logic [31:0] entry_va(logic [31:0] r);
        return {m_tlb[r[31:28]].vppn, r[12:0]};
    endfunction

    initial begin
        logic [31:0]          r;
        logic [31:0]          va;
        xlat_pkg::tlb_entry_t e;
        int                   seen_before;
        logic                 saw_ready_low;

        void'($urandom(32'h068e_5ba5));
        clk        = 1'b0;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_va     = '0;
        req_kind   = xlat_pkg::acc_fetch;
        csr_we     = 1'b0;
        csr_sel    = '0;
        csr_wdata  = '0;
        tlb_we     = 1'b0;
        tlb_index  = '0;
        tlb_wentry = '0;
        flush_req  = 1'b0;
        m_da       = 1'b0;
        m_plv      = '0;
        m_asid     = '0;
        m_dmw0     = '0;
        m_dmw1     = '0;
        for (int i = 0; i < xlat_pkg::tlb_num; i++) begin
            m_tlb[i] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // direct mode
        r = $urandom;
        set_mode(1'b1, r[1:0]);
        for (int n = 0; n < 48; n++) begin
            r = $urandom;
            send($urandom, xlat_pkg::acc_kind_t'(r[0]));
        end
        stop_req();
        wait_idle();

        // unique entries, the low vppn bits carry the index
        set_asid(10'h15a);
        for (int i = 0; i < xlat_pkg::tlb_num; i++) begin
            r = $urandom;
            e.e     = 1'b1;
            e.vppn  = {r[14:0], 4'(i)};
            e.g     = r[15];
            e.asid  = r[16] ? m_asid : 10'h0a5;
            r = $urandom;
            e.page0 = {r[19:0], r[21:20], r[23:22] != 2'b00};
            r = $urandom;
            e.page1 = {r[19:0], r[21:20], r[23:22] != 2'b00};
            write_entry(4'(i), e);
        end

        // windows, then overlap, then disabled for the current level
        set_mode(1'b0, 2'd1);
        set_window(1'b0, 4'hf, 3'd1, 3'd4);
        set_window(1'b1, 4'hf, 3'd2, 3'd6);
        for (int phase = 0; phase < 3; phase++) begin
            if (phase == 1) begin
                set_window(1'b1, 4'hf, 3'd3, 3'd4);
            end else if (phase == 2) begin
                set_window(1'b0, 4'b1101, 3'd1, 3'd4);
                set_window(1'b1, 4'b1101, 3'd3, 3'd4);
            end
            for (int n = 0; n < 24; n++) begin
                r  = $urandom;
                va = $urandom;
                if (phase == 2) begin
                    va = entry_va(r);
                    // half of them inside the disabled segment
                    if (r[3]) begin
                        va[31:29] = 3'd4;
                    end
                end else if (r[1:0] == 2'd0) begin
                    va[31:29] = 3'd4;
                end else if (r[1:0] == 2'd1) begin
                    va[31:29] = 3'd6;
                end
                send(va, xlat_pkg::acc_kind_t'(r[2]));
            end
            stop_req();
            wait_idle();
        end

        // tlb lookups at every privilege level
        set_window(1'b0, 4'h0, 3'd0, 3'd0);
        set_window(1'b1, 4'h0, 3'd0, 3'd0);
        for (int plv = 0; plv < 4; plv++) begin
            set_mode(1'b0, 2'(plv));
            for (int n = 0; n < 20; n++) begin
                r  = $urandom;
                va = (r[7:5] == 3'd0) ? $urandom : entry_va(r);
                send(va, xlat_pkg::acc_kind_t'(r[4]));
            end
            stop_req();
            wait_idle();
        end

        // flush with requests in flight
        set_mode(1'b0, 2'd0);
        for (int n = 0; n < 6; n++) begin
            r = $urandom;
            send(entry_va(r), xlat_pkg::acc_load);
        end
        @(negedge clk);
        req_valid = 1'b0;
        flush_req = 1'b1;
        @(negedge clk);
        flush_req = 1'b0;
        assert (flush_busy) else begin
            proto_errors++;
            $display("%0t: flush_busy did not rise after the flush pulse", $time);
        end
        while (flush_busy) begin
            @(negedge clk);
        end
        wait_idle();
        for (int i = 0; i < xlat_pkg::tlb_num; i++) begin
            m_tlb[i].e = 1'b0;
        end
        for (int i = 0; i < xlat_pkg::tlb_num; i++) begin
            r = $urandom;
            send({m_tlb[i].vppn, r[12:0]}, xlat_pkg::acc_fetch);
        end
        stop_req();
        wait_idle();

        // credits withheld while a burst is sent
        set_mode(1'b1, 2'd0);
        withhold      = 1'b1;
        seen_before   = rsp_seen;
        saw_ready_low = 1'b0;
        fork
            begin
                for (int n = 0; n < 12; n++) begin
                    send($urandom, xlat_pkg::acc_fetch);
                end
                stop_req();
            end
            begin
                repeat (40) begin
                    @(negedge clk);
                    if (!req_ready) begin
                        saw_ready_low = 1'b1;
                    end
                end
                assert (rsp_seen - seen_before <= xlat_pkg::xlat_credits) else begin
                    proto_errors++;
                    $display("%0t: more responses than credits while credits were held back",
                             $time);
                end
                assert (saw_ready_low) else begin
                    proto_errors++;
                    $display("%0t: req_ready never dropped without credit", $time);
                end
                withhold = 1'b0;
            end
        join
        wait_idle();

        $display("errors: value %0d, protocol %0d", val_errors, proto_errors);
        if (val_errors == 0 && proto_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/xlat_unit.sv ====
module xlat_unit (
    input  logic                           clk,
    input  logic                           rst_n,

    input  logic                           req_valid,
    input  logic [xlat_pkg::va_w-1:0]      req_va,
    input  xlat_pkg::acc_kind_t            req_kind,
    output logic                           req_ready,

    output logic                           rsp_valid,
    output logic [xlat_pkg::va_w-1:0]      rsp_pa,
    output logic [xlat_pkg::ecode_w-1:0]   rsp_ecode,
    input  logic                           rsp_credit,

    input  logic                           csr_we,
    input  logic [1:0]                     csr_sel,
    input  logic [xlat_pkg::csr_w-1:0]     csr_wdata,

    input  logic                           tlb_we,
    input  logic [xlat_pkg::tlb_idx_w-1:0] tlb_index,
    input  xlat_pkg::tlb_entry_t           tlb_wentry,

    input  logic                           flush_req,
    output logic                           flush_busy
);

    xlat_pkg::xlat_cfg_t            cfg;
    logic                           hold_req;
    logic                           inv_strobe;
    logic [xlat_pkg::tlb_idx_w-1:0] inv_index;
    logic                           pipe_empty;
    logic                           has_credit;

    // tlb writes are dropped during a flush
    wire tlb_we_open = tlb_we && !flush_busy;

    tlb_lookup_if lookup0 ();

    csr_regs csr0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .csr_we    (csr_we),
        .csr_sel   (csr_sel),
        .csr_wdata (csr_wdata),
        .cfg       (cfg)
    );

    tlb_array tlb0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .we         (tlb_we_open),
        .windex     (tlb_index),
        .wentry     (tlb_wentry),
        .inv_strobe (inv_strobe),
        .inv_index  (inv_index),
        .lookup     (lookup0.responder)
    );

    flush_ctrl flush0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush_req  (flush_req),
        .pipe_empty (pipe_empty),
        .hold_req   (hold_req),
        .inv_strobe (inv_strobe),
        .inv_index  (inv_index),
        .flush_busy (flush_busy)
    );

    credit_counter credit0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .spend      (rsp_valid),
        .give_back  (rsp_credit),
        .has_credit (has_credit)
    );

    xlat_pipe pipe0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_va     (req_va),
        .req_kind   (req_kind),
        .req_ready  (req_ready),
        .cfg        (cfg),
        .hold_req   (hold_req),
        .has_credit (has_credit),
        .lookup     (lookup0.requester),
        .rsp_valid  (rsp_valid),
        .rsp_pa     (rsp_pa),
        .rsp_ecode  (rsp_ecode),
        .pipe_empty (pipe_empty)
    );

endmodule

// ==== logic/xlat_pipe.sv ====
module xlat_pipe (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         req_valid,
    input  logic [xlat_pkg::va_w-1:0]    req_va,
    input  xlat_pkg::acc_kind_t          req_kind,
    output logic                         req_ready,
    input  xlat_pkg::xlat_cfg_t          cfg,
    input  logic                         hold_req,
    input  logic                         has_credit,
    tlb_lookup_if.requester              lookup,
    output logic                         rsp_valid,
    output logic [xlat_pkg::va_w-1:0]    rsp_pa,
    output logic [xlat_pkg::ecode_w-1:0] rsp_ecode,
    output logic                         pipe_empty
);

    xlat_pkg::xlat_req_t req_in;
    xlat_pkg::xlat_req_t s1_req;
    xlat_pkg::xlat_rsp_t s1_rsp;
    xlat_pkg::xlat_rsp_t s2_rsp;
    logic                s1_valid;
    logic                s2_valid;
    logic                s1_hold;
    logic                s2_hold;
    logic                dmw0_hit;
    logic                dmw1_hit;
    logic [xlat_pkg::va_w-1:0] va;

    // stall chain from the response end backwards
    assign s2_hold   = s2_valid && !has_credit;
    assign s1_hold   = s1_valid && s2_hold;
    assign req_ready = !hold_req && !s1_hold;

    assign req_in.va   = req_va;
    assign req_in.kind = req_kind;

    pipe_stage #(.payload_t(xlat_pkg::xlat_req_t)) req_stage (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (req_valid && req_ready),
        .hold  (s1_hold),
        .din   (req_in),
        .valid (s1_valid),
        .dout  (s1_req)
    );

    assign va = s1_req.va;

    assign lookup.vppn = va[xlat_pkg::va_w-1:13];
    assign lookup.odd  = va[12];
    assign lookup.asid = cfg.asid;

    assign dmw0_hit = cfg.dmw0.plv_en[cfg.plv]
                   && (va[xlat_pkg::va_w-1 -: xlat_pkg::seg_w] == cfg.dmw0.vseg);
    assign dmw1_hit = cfg.dmw1.plv_en[cfg.plv]
                   && (va[xlat_pkg::va_w-1 -: xlat_pkg::seg_w] == cfg.dmw1.vseg);

    // priority: direct, window 0, window 1, then tlb
    always_comb begin
        s1_rsp.pa    = '0;
        s1_rsp.ecode = xlat_pkg::ecode_none;
        if (cfg.da) begin
            s1_rsp.pa = va;
        end else if (dmw0_hit) begin
            s1_rsp.pa = {cfg.dmw0.pseg, va[xlat_pkg::va_w-xlat_pkg::seg_w-1:0]};
        end else if (dmw1_hit) begin
            s1_rsp.pa = {cfg.dmw1.pseg, va[xlat_pkg::va_w-xlat_pkg::seg_w-1:0]};
        end else if (!lookup.found) begin
            s1_rsp.ecode = xlat_pkg::ecode_tlbr;
        end else if (!lookup.page.v) begin
            s1_rsp.ecode = (s1_req.kind == xlat_pkg::acc_fetch) ? xlat_pkg::ecode_pif
                                                                : xlat_pkg::ecode_pil;
        end else if (cfg.plv > lookup.page.plv) begin
            s1_rsp.ecode = xlat_pkg::ecode_ppi;
        end else begin
            s1_rsp.pa = {lookup.page.ppn, va[11:0]};
        end
    end

    pipe_stage #(.payload_t(xlat_pkg::xlat_rsp_t)) rsp_stage (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (s1_valid),
        .hold  (s2_hold),
        .din   (s1_rsp),
        .valid (s2_valid),
        .dout  (s2_rsp)
    );

    // a response goes out only while credit is held
    assign rsp_valid  = s2_valid && has_credit;
    assign rsp_pa     = s2_rsp.pa;
    assign rsp_ecode  = s2_rsp.ecode;
    assign pipe_empty = !s1_valid && !s2_valid;

endmodule

// ==== logic/pipe_stage.sv ====
module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load,
    input  logic     hold,
    input  payload_t din,
    output logic     valid,
    output payload_t dout
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (!hold) begin
            valid <= load;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold && load) begin
            dout <= din;
        end
    end

endmodule

// ==== logic/credit_counter.sv ====
module credit_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic spend,
    input  logic give_back,
    output logic has_credit
);

    localparam int cnt_w = $clog2(xlat_pkg::xlat_credits + 1);

    logic [cnt_w-1:0] count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= cnt_w'(xlat_pkg::xlat_credits);
        end else if (spend && !give_back) begin
            count <= count - 1'b1;
        end else if (give_back && !spend) begin
            count <= count + 1'b1;
        end
    end

    assign has_credit = (count != '0);

endmodule

// ==== logic/flush_ctrl.sv ====
module flush_ctrl (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           flush_req,
    input  logic                           pipe_empty,
    output logic                           hold_req,
    output logic                           inv_strobe,
    output logic [xlat_pkg::tlb_idx_w-1:0] inv_index,
    output logic                           flush_busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_drain,
        st_sweep
    } flush_state_t;

    flush_state_t                   state;
    logic [xlat_pkg::tlb_idx_w-1:0] sweep_idx;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_idle;
            sweep_idx <= '0;
        end else begin
            case (state)
                st_idle: begin
                    sweep_idx <= '0;
                    if (flush_req) begin
                        state <= st_drain;
                    end
                end
                // wait for in-flight requests to leave
                st_drain: begin
                    if (pipe_empty) begin
                        state <= st_sweep;
                    end
                end
                st_sweep: begin
                    sweep_idx <= sweep_idx + 1'b1;
                    if (sweep_idx == xlat_pkg::tlb_idx_w'(xlat_pkg::tlb_num - 1)) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign flush_busy = (state != st_idle);
    assign hold_req   = flush_busy;
    assign inv_strobe = (state == st_sweep);
    assign inv_index  = sweep_idx;

endmodule

// ==== logic/tlb_array.sv ====
module tlb_array (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           we,
    input  logic [xlat_pkg::tlb_idx_w-1:0] windex,
    input  xlat_pkg::tlb_entry_t           wentry,
    input  logic                           inv_strobe,
    input  logic [xlat_pkg::tlb_idx_w-1:0] inv_index,
    tlb_lookup_if.responder                lookup
);

    xlat_pkg::tlb_entry_t             entries [xlat_pkg::tlb_num];
    logic [xlat_pkg::tlb_num-1:0]     entry_e;
    logic [xlat_pkg::tlb_num-1:0]     hit;

    // entry contents, no reset needed
    always_ff @(posedge clk) begin
        if (we) begin
            entries[windex] <= wentry;
        end
    end

    // valid bits kept apart so reset can clear them
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            entry_e <= '0;
        end else begin
            if (we) begin
                entry_e[windex] <= wentry.e;
            end
            if (inv_strobe) begin
                entry_e[inv_index] <= 1'b0;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < xlat_pkg::tlb_num; i++) begin
            hit[i] = entry_e[i]
                  && (entries[i].vppn == lookup.vppn)
                  && (entries[i].g || (entries[i].asid == lookup.asid));
        end
    end

    // entries are unique, so at most one hit
    always_comb begin
        lookup.found = 1'b0;
        lookup.page  = '0;
        for (int i = 0; i < xlat_pkg::tlb_num; i++) begin
            if (hit[i]) begin
                lookup.found = 1'b1;
                lookup.page  = lookup.odd ? entries[i].page1 : entries[i].page0;
            end
        end
    end

endmodule

// ==== logic/csr_regs.sv ====
module csr_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       csr_we,
    input  logic [1:0]                 csr_sel,
    input  logic [xlat_pkg::csr_w-1:0] csr_wdata,
    output xlat_pkg::xlat_cfg_t        cfg
);

    logic                          crmd_da;
    logic [xlat_pkg::plv_w-1:0]    crmd_plv;
    logic [xlat_pkg::asid_w-1:0]   asid;
    xlat_pkg::dmw_t                dmw0;
    xlat_pkg::dmw_t                dmw1;
    xlat_pkg::dmw_t                dmw_wdata;

    // window layout: vseg 31:29, pseg 27:25, level enables 3:0
    assign dmw_wdata.plv_en = csr_wdata[3:0];
    assign dmw_wdata.pseg   = csr_wdata[27:25];
    assign dmw_wdata.vseg   = csr_wdata[31:29];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crmd_da  <= 1'b0;
            crmd_plv <= '0;
            asid     <= '0;
            dmw0     <= '0;
            dmw1     <= '0;
        end else if (csr_we) begin
            case (csr_sel)
                xlat_pkg::csr_sel_crmd: begin
                    crmd_da  <= csr_wdata[3];
                    crmd_plv <= csr_wdata[1:0];
                end
                xlat_pkg::csr_sel_asid: asid <= csr_wdata[xlat_pkg::asid_w-1:0];
                xlat_pkg::csr_sel_dmw0: dmw0 <= dmw_wdata;
                default:                dmw1 <= dmw_wdata;
            endcase
        end
    end

    assign cfg.da   = crmd_da;
    assign cfg.plv  = crmd_plv;
    assign cfg.asid = asid;
    assign cfg.dmw0 = dmw0;
    assign cfg.dmw1 = dmw1;

endmodule

// ==== logic/tlb_lookup_if.sv ====
interface tlb_lookup_if;

    logic [xlat_pkg::vppn_w-1:0] vppn;
    logic                        odd;
    logic [xlat_pkg::asid_w-1:0] asid;
    logic                        found;
    xlat_pkg::tlb_page_t         page;

    modport requester (
        output vppn,
        output odd,
        output asid,
        input  found,
        input  page
    );

    modport responder (
        input  vppn,
        input  odd,
        input  asid,
        output found,
        output page
    );

endinterface

// ==== logic/xlat_pkg.sv ====
package xlat_pkg;

    localparam int va_w         = 32;
    localparam int csr_w        = 32;
    localparam int vppn_w       = 19;
    localparam int ppn_w        = 20;
    localparam int asid_w       = 10;
    localparam int plv_w        = 2;
    localparam int seg_w        = 3;
    localparam int ecode_w      = 6;
    localparam int tlb_num      = 16;
    localparam int tlb_idx_w    = 4;
    localparam int xlat_credits = 4;

    localparam logic [ecode_w-1:0] ecode_none = 6'h00;
    localparam logic [ecode_w-1:0] ecode_tlbr = 6'h3f;
    localparam logic [ecode_w-1:0] ecode_pif  = 6'h03;
    localparam logic [ecode_w-1:0] ecode_pil  = 6'h01;
    localparam logic [ecode_w-1:0] ecode_ppi  = 6'h07;

    localparam logic [1:0] csr_sel_crmd = 2'd0;
    localparam logic [1:0] csr_sel_asid = 2'd1;
    localparam logic [1:0] csr_sel_dmw0 = 2'd2;
    localparam logic [1:0] csr_sel_dmw1 = 2'd3;

    typedef enum logic {
        acc_fetch = 1'b0,
        acc_load  = 1'b1
    } acc_kind_t;

    typedef struct packed {
        logic [ppn_w-1:0] ppn;
        logic [plv_w-1:0] plv;
        logic             v;
    } tlb_page_t;

    typedef struct packed {
        logic              e;
        logic [vppn_w-1:0] vppn;
        logic [asid_w-1:0] asid;
        logic              g;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_t;

    // one enable bit per privilege level
    typedef struct packed {
        logic [3:0]       plv_en;
        logic [seg_w-1:0] pseg;
        logic [seg_w-1:0] vseg;
    } dmw_t;

    typedef struct packed {
        logic              da;
        logic [plv_w-1:0]  plv;
        logic [asid_w-1:0] asid;
        dmw_t              dmw0;
        dmw_t              dmw1;
    } xlat_cfg_t;

    typedef struct packed {
        logic [va_w-1:0] va;
        acc_kind_t       kind;
    } xlat_req_t;

    typedef struct packed {
        logic [va_w-1:0]    pa;
        logic [ecode_w-1:0] ecode;
    } xlat_rsp_t;

endpackage
